// ==== common/riscv_consts.svh ====
`ifndef RISCV_CONSTS_SVH
`define RISCV_CONSTS_SVH

// Datapath and memory geometry
`define XLEN 32
`define ADDR_W 12

// Fetch starts here after reset
`define RESET_PC 32'h0000_0000

// Halt is JALR x0,0(x1) while x1 holds the return address
`define HALT_INST 32'h0000_8067
`define HALT_RA 32'd12

// Register file addressing
`define REG_ADDR_W 5

// Counter width for completed instructions
`define CNT_W 32

`endif

// ==== common/rvIsaPkg.sv ====
package rvIsaPkg;

	typedef enum logic [6:0] {
		OP_LUI = 7'b0110111,
		OP_AUIPC = 7'b0010111,
		OP_JAL = 7'b1101111,
		OP_JALR = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD = 7'b0000011,
		OP_STORE = 7'b0100011,
		OP_IMM = 7'b0010011,
		OP_REG = 7'b0110011
	} opcodeE;

	// funct3 of OP and OP-IMM
	typedef enum logic [2:0] {
		F3_ADD = 3'b000,
		F3_SLL = 3'b001,
		F3_SLT = 3'b010,
		F3_SLTU = 3'b011,
		F3_XOR = 3'b100,
		F3_SR = 3'b101, // SRL or SRA by funct7
		F3_OR = 3'b110,
		F3_AND = 3'b111
	} aluF3E;

	typedef enum logic [2:0] {
		F3_BEQ = 3'b000,
		F3_BNE = 3'b001,
		F3_BLT = 3'b100,
		F3_BGE = 3'b101,
		F3_BLTU = 3'b110,
		F3_BGEU = 3'b111
	} branchF3E;

	typedef struct packed {
		logic [6:0] funct7; // bit 5 selects SUB and SRA
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcodeE opcode;
	} rType;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcodeE opcode;
	} iType;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] immLo;
		opcodeE opcode;
	} sType;

	typedef struct packed {
		logic immSign;
		logic [5:0] immHi; // imm[10:5]
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] immLo; // imm[4:1]
		logic immBit11;
		opcodeE opcode;
	} bType;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0] rd;
		opcodeE opcode;
	} uType;

	typedef struct packed {
		logic immSign;
		logic [9:0] immLo; // imm[10:1]
		logic immBit11;
		logic [7:0] immHi; // imm[19:12]
		logic [4:0] rd;
		opcodeE opcode;
	} jType;

	// One fetched word seen through every format
	typedef union packed {
		rType r;
		iType i;
		sType s;
		bType b;
		uType u;
		jType j;
	} instrU;

endpackage

// ==== common/rvCtrlPkg.sv ====
package rvCtrlPkg;

	// Low codes follow {funct7[5], funct3} for the ALU ops
	typedef enum logic [3:0] {
		ALU_ADD = 4'h0,
		ALU_SLL = 4'h1,
		ALU_SLT = 4'h2,
		ALU_SLTU = 4'h3,
		ALU_XOR = 4'h4,
		ALU_SRL = 4'h5,
		ALU_OR = 4'h6,
		ALU_AND = 4'h7,
		ALU_SUB = 4'h8,
		ALU_BEQ = 4'h9,
		ALU_BNE = 4'hA,
		ALU_BLT = 4'hB,
		ALU_BGE = 4'hC,
		ALU_SRA = 4'hD,
		ALU_BLTU = 4'hE,
		ALU_BGEU = 4'hF
	} aluOpE;

	typedef enum logic {A_RS1, A_PC} aSelE;

	typedef enum logic {B_RS2, B_IMM} bSelE;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_IMM} wbSelE;

	typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} immSelE;

	typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pcSelE;

	typedef struct packed {
		aluOpE aluOp;
		aSelE aSel;
		bSelE bSel;
		wbSelE wbSel;
		immSelE immSel;
		pcSelE pcSel;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic halt;
	} ctrlS;

endpackage

// ==== logic/riscvDecoder.sv ====
`include "riscv_consts.svh"

module riscvDecoder (
	input rvIsaPkg::instrU instr,
	input logic [`XLEN-1:0] rs1Data,
	input logic RSTn,
	output rvCtrlPkg::ctrlS ctrl
);

	logic isHalt;

	function automatic rvCtrlPkg::aluOpE aluOpOf(input logic [2:0] funct3, input logic alt);
		unique case (funct3)
			rvIsaPkg::F3_ADD: return alt ? rvCtrlPkg::ALU_SUB : rvCtrlPkg::ALU_ADD;
			rvIsaPkg::F3_SLL: return rvCtrlPkg::ALU_SLL;
			rvIsaPkg::F3_SLT: return rvCtrlPkg::ALU_SLT;
			rvIsaPkg::F3_SLTU: return rvCtrlPkg::ALU_SLTU;
			rvIsaPkg::F3_XOR: return rvCtrlPkg::ALU_XOR;
			rvIsaPkg::F3_SR: return alt ? rvCtrlPkg::ALU_SRA : rvCtrlPkg::ALU_SRL;
			rvIsaPkg::F3_OR: return rvCtrlPkg::ALU_OR;
			default: return rvCtrlPkg::ALU_AND;
		endcase
	endfunction

	function automatic rvCtrlPkg::aluOpE branchOpOf(input logic [2:0] funct3);
		case (funct3)
			rvIsaPkg::F3_BEQ: return rvCtrlPkg::ALU_BEQ;
			rvIsaPkg::F3_BNE: return rvCtrlPkg::ALU_BNE;
			rvIsaPkg::F3_BLT: return rvCtrlPkg::ALU_BLT;
			rvIsaPkg::F3_BGE: return rvCtrlPkg::ALU_BGE;
			rvIsaPkg::F3_BLTU: return rvCtrlPkg::ALU_BLTU;
			rvIsaPkg::F3_BGEU: return rvCtrlPkg::ALU_BGEU;
			default: return rvCtrlPkg::ALU_ADD; // never taken
		endcase
	endfunction

	assign isHalt = (instr == `HALT_INST) && (rs1Data == `HALT_RA);

	always_comb begin
		ctrl.aluOp = rvCtrlPkg::ALU_ADD;
		ctrl.aSel = rvCtrlPkg::A_RS1;
		ctrl.bSel = rvCtrlPkg::B_RS2;
		ctrl.wbSel = rvCtrlPkg::WB_ALU;
		ctrl.immSel = rvCtrlPkg::IMM_I;
		ctrl.pcSel = rvCtrlPkg::PC_SEQ;
		ctrl.regWrite = 1'b0;
		ctrl.memRead = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.halt = 1'b0;

		if (!RSTn) begin
			case (instr.r.opcode)
				rvIsaPkg::OP_LUI: begin
					ctrl.immSel = rvCtrlPkg::IMM_U;
					ctrl.wbSel = rvCtrlPkg::WB_IMM;
					ctrl.regWrite = 1'b1;
				end
				rvIsaPkg::OP_AUIPC: begin
					ctrl.aSel = rvCtrlPkg::A_PC;
					ctrl.bSel = rvCtrlPkg::B_IMM;
					ctrl.immSel = rvCtrlPkg::IMM_U;
					ctrl.regWrite = 1'b1;
				end
				rvIsaPkg::OP_JAL: begin
					ctrl.immSel = rvCtrlPkg::IMM_J;
					ctrl.wbSel = rvCtrlPkg::WB_PC4;
					ctrl.pcSel = rvCtrlPkg::PC_JAL;
					ctrl.regWrite = 1'b1;
				end
				rvIsaPkg::OP_JALR: begin
					ctrl.bSel = rvCtrlPkg::B_IMM; // target is rs1 + imm
					ctrl.wbSel = rvCtrlPkg::WB_PC4;
					ctrl.pcSel = rvCtrlPkg::PC_JALR;
					ctrl.regWrite = 1'b1;
				end
				rvIsaPkg::OP_BRANCH: begin
					ctrl.aluOp = branchOpOf(instr.b.funct3);
					ctrl.immSel = rvCtrlPkg::IMM_B;
					ctrl.pcSel = rvCtrlPkg::PC_BRANCH;
				end
				rvIsaPkg::OP_LOAD: begin
					ctrl.bSel = rvCtrlPkg::B_IMM;
					ctrl.wbSel = rvCtrlPkg::WB_MEM;
					ctrl.memRead = 1'b1;
					ctrl.regWrite = 1'b1;
				end
				rvIsaPkg::OP_STORE: begin
					ctrl.bSel = rvCtrlPkg::B_IMM;
					ctrl.immSel = rvCtrlPkg::IMM_S;
					ctrl.memWrite = 1'b1;
				end
				rvIsaPkg::OP_IMM: begin
					// funct7 only matters for the right shift here
					ctrl.aluOp = aluOpOf(instr.i.funct3,
						(instr.i.funct3 == rvIsaPkg::F3_SR) && instr.r.funct7[5]);
					ctrl.bSel = rvCtrlPkg::B_IMM;
					ctrl.regWrite = 1'b1;
				end
				rvIsaPkg::OP_REG: begin
					ctrl.aluOp = aluOpOf(instr.r.funct3, instr.r.funct7[5]);
					ctrl.regWrite = 1'b1;
				end
				default: ; // Unsupported words retire as no-ops
			endcase
			ctrl.halt = isHalt;
		end

		if (ctrl.halt) begin
			ctrl.regWrite = 1'b0;
			ctrl.memWrite = 1'b0;
		end
	end

endmodule

// ==== logic/immGen.sv ====
`include "riscv_consts.svh"

module immGen (
	input rvIsaPkg::instrU instr,
	input rvCtrlPkg::immSelE immSel,
	output logic [`XLEN-1:0] imm
);

	logic [`XLEN-1:0] immI;
	logic [`XLEN-1:0] immS;
	logic [`XLEN-1:0] immB;
	logic [`XLEN-1:0] immU;
	logic [`XLEN-1:0] immJ;

	assign immI = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
	assign immS = {{(`XLEN-12){instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};

	// Branch offsets are even, bit 0 is implied
	assign immB = {{(`XLEN-12){instr.b.immSign}}, instr.b.immBit11,
		instr.b.immHi, instr.b.immLo, 1'b0};

	assign immU = {instr.u.imm, 12'b0};

	assign immJ = {{(`XLEN-20){instr.j.immSign}}, instr.j.immHi,
		instr.j.immBit11, instr.j.immLo, 1'b0};

	always_comb begin
		case (immSel)
			rvCtrlPkg::IMM_S: imm = immS;
			rvCtrlPkg::IMM_B: imm = immB;
			rvCtrlPkg::IMM_U: imm = immU;
			rvCtrlPkg::IMM_J: imm = immJ;
			default: imm = immI; // also covers shamt
		endcase
	end

endmodule

// ==== logic/alu.sv ====
`include "riscv_consts.svh"

module alu (
	input logic [`XLEN-1:0] a,
	input logic [`XLEN-1:0] b,
	input rvCtrlPkg::aluOpE op,
	output logic [`XLEN-1:0] result,
	output logic taken
);

	localparam int SHW = $clog2(`XLEN);

	logic [SHW-1:0] shamt;
	logic [`XLEN-1:0] diff;
	logic eq;
	logic lt;
	logic ltu;

	assign shamt = b[SHW-1:0];
	assign diff = a - b;
	assign eq = (a == b);
	assign lt = ($signed(a) < $signed(b));
	assign ltu = (a < b);

	always_comb begin
		unique case (op)
			rvCtrlPkg::ALU_ADD: result = a + b;
			rvCtrlPkg::ALU_SUB: result = diff;
			rvCtrlPkg::ALU_SLL: result = a << shamt;
			rvCtrlPkg::ALU_SRL: result = a >> shamt;
			rvCtrlPkg::ALU_SRA: result = $signed(a) >>> shamt;
			rvCtrlPkg::ALU_SLT: result = `XLEN'(lt);
			rvCtrlPkg::ALU_SLTU: result = `XLEN'(ltu);
			rvCtrlPkg::ALU_XOR: result = a ^ b;
			rvCtrlPkg::ALU_OR: result = a | b;
			rvCtrlPkg::ALU_AND: result = a & b;
			default: result = diff; // Branch compares
		endcase
	end

	// Branch condition, low for every non-branch op
	always_comb begin
		case (op)
			rvCtrlPkg::ALU_BEQ: taken = eq;
			rvCtrlPkg::ALU_BNE: taken = !eq;
			rvCtrlPkg::ALU_BLT: taken = lt;
			rvCtrlPkg::ALU_BGE: taken = !lt;
			rvCtrlPkg::ALU_BLTU: taken = ltu;
			rvCtrlPkg::ALU_BGEU: taken = !ltu;
			default: taken = 1'b0;
		endcase
	end

endmodule

// ==== logic/nextPc.sv ====
`include "riscv_consts.svh"

module nextPc (
	input logic CLK,
	input logic RSTn,
	input rvCtrlPkg::ctrlS ctrl,
	input logic taken,
	input logic [`XLEN-1:0] imm,
	input logic [`XLEN-1:0] aluResult,
	output logic [`XLEN-1:0] pc,
	output logic [`XLEN-1:0] pcPlus4,
	output logic [`CNT_W-1:0] numInst
);

	logic [`XLEN-1:0] pcTarget;
	logic [`XLEN-1:0] pcNext;

	assign pcPlus4 = pc + `XLEN'd4;
	assign pcTarget = pc + imm; // Shared by branches and JAL

	always_comb begin
		case (ctrl.pcSel)
			rvCtrlPkg::PC_BRANCH: pcNext = taken ? pcTarget : pcPlus4;
			rvCtrlPkg::PC_JAL: pcNext = pcTarget;
			rvCtrlPkg::PC_JALR: pcNext = {aluResult[`XLEN-1:1], 1'b0};
			default: pcNext = pcPlus4;
		endcase
		if (ctrl.halt) begin
			pcNext = pc; // Spin on the halt word
		end
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= `RESET_PC;
		end else begin
			pc <= pcNext;
		end
	end

	// One instruction retires per cycle until halt
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			numInst <= '0;
		end else if (!ctrl.halt) begin
			numInst <= numInst + 1'b1;
		end
	end

endmodule

// ==== logic/riscvTop.sv ====
`include "riscv_consts.svh"

module riscvTop (
	input logic CLK,
	input logic RSTn,

	output logic iMemCsn,
	input logic [`XLEN-1:0] iMemData,
	output logic [`ADDR_W-1:0] iMemAddr, // byte address

	output logic dMemCsn,
	input logic [`XLEN-1:0] dMemDi,
	output logic [`XLEN-1:0] dMemDout,
	output logic [`ADDR_W-1:0] dMemAddr,
	output logic dMemWen,

	output logic rfWe,
	output logic [`REG_ADDR_W-1:0] rfRa1,
	output logic [`REG_ADDR_W-1:0] rfRa2,
	output logic [`REG_ADDR_W-1:0] rfWa,
	input logic [`XLEN-1:0] rfRd1,
	input logic [`XLEN-1:0] rfRd2,
	output logic [`XLEN-1:0] rfWd,
	output logic halt,
	output logic [`CNT_W-1:0] numInst
);

	rvIsaPkg::instrU instr;
	rvCtrlPkg::ctrlS ctrl;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] pcPlus4;
	logic [`XLEN-1:0] aluA;
	logic [`XLEN-1:0] aluB;
	logic [`XLEN-1:0] aluResult;
	logic taken;

	assign instr = iMemData;

	riscvDecoder u_decoder (.instr(instr), .rs1Data(rfRd1), .RSTn(RSTn), .ctrl(ctrl));

	immGen u_immGen (.instr(instr), .immSel(ctrl.immSel), .imm(imm));

	assign aluA = (ctrl.aSel == rvCtrlPkg::A_PC) ? pc : rfRd1;
	assign aluB = (ctrl.bSel == rvCtrlPkg::B_IMM) ? imm : rfRd2;

	alu u_alu (.a(aluA), .b(aluB), .op(ctrl.aluOp), .result(aluResult), .taken(taken));

	nextPc u_nextPc (
		.CLK(CLK),
		.RSTn(RSTn),
		.ctrl(ctrl),
		.taken(taken),
		.imm(imm),
		.aluResult(aluResult),
		.pc(pc),
		.pcPlus4(pcPlus4),
		.numInst(numInst)
	);

	assign iMemCsn = RSTn; // Fetch enabled once out of reset
	assign iMemAddr = pc[`ADDR_W-1:0];

	assign rfRa1 = instr.r.rs1;
	assign rfRa2 = instr.r.rs2;
	assign rfWa = instr.r.rd;
	assign rfWe = ctrl.regWrite;

	// Word accesses only
	assign dMemCsn = !(ctrl.memRead || ctrl.memWrite);
	assign dMemWen = !ctrl.memWrite;
	assign dMemAddr = aluResult[`ADDR_W-1:0];
	assign dMemDout = rfRd2;

	always_comb begin
		case (ctrl.wbSel)
			rvCtrlPkg::WB_MEM: rfWd = dMemDi;
			rvCtrlPkg::WB_PC4: rfWd = pcPlus4; // link value
			rvCtrlPkg::WB_IMM: rfWd = imm;
			default: rfWd = aluResult;
		endcase
	end

	assign halt = ctrl.halt;

endmodule

// ==== dv/tbClock.sv ====
module tbClock (
	output logic CLK,
	output logic RSTn
);

	localparam int HALF_PERIOD = 50;
	localparam int RESET_CYCLES = 5;

	initial begin
		CLK = 1'b0;
		forever #HALF_PERIOD CLK = ~CLK;
	end

	// Reset is active high, released just after an edge
	initial begin
		RSTn = 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK);
		#1 RSTn = 1'b0;
	end

endmodule

// ==== dv/tbRiscvTop.sv ====
`include "riscv_consts.svh"

module tbRiscvTop;

	localparam int MEM_WORDS = 1 << (`ADDR_W - 2);

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} expT;

	logic CLK;
	logic RSTn;
	logic iMemCsn;
	logic [`XLEN-1:0] iMemData;
	logic [`ADDR_W-1:0] iMemAddr;
	logic dMemCsn;
	logic [`XLEN-1:0] dMemDi;
	logic [`XLEN-1:0] dMemDout;
	logic [`ADDR_W-1:0] dMemAddr;
	logic dMemWen;
	logic rfWe;
	logic [`REG_ADDR_W-1:0] rfRa1;
	logic [`REG_ADDR_W-1:0] rfRa2;
	logic [`REG_ADDR_W-1:0] rfWa;
	logic [`XLEN-1:0] rfRd1;
	logic [`XLEN-1:0] rfRd2;
	logic [`XLEN-1:0] rfWd;
	logic halt;
	logic [`CNT_W-1:0] numInst;

	logic [`XLEN-1:0] iMem [0:MEM_WORDS-1];
	logic [`XLEN-1:0] dMem [0:MEM_WORDS-1];
	logic [`XLEN-1:0] regs [0:31];

	expT regQ[$];
	expT storeQ[$];
	logic [31:0] expCount = 0;
	logic [31:0] haltPc = '1;
	int cycleLimit = 20;
	int cycles = 0;
	int checkCount = 0;
	int errCount = 0;
	int otherErrors = 0;

	tbClock u_clock (.CLK(CLK), .RSTn(RSTn));

	riscvTop i_riscvTop (.*);

	// Asynchronous reads, writes on the rising edge
	assign iMemData = iMem[iMemAddr[`ADDR_W-1:2]];
	assign dMemDi = dMem[dMemAddr[`ADDR_W-1:2]];
	assign rfRd1 = regs[rfRa1];
	assign rfRd2 = regs[rfRa2];

	always @(posedge CLK) begin
		if (rfWe && rfWa != 0) begin
			regs[rfWa] <= rfWd;
		end
		if (!dMemCsn && !dMemWen) begin
			dMem[dMemAddr[`ADDR_W-1:2]] <= dMemDout; // word index
		end
	end

	task automatic compareValues(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount++;
		if (got !== expected) begin
			errCount++;
			$display("ERROR at %0t: %s is %h, expected %h", $time, what, got, expected);
		end
	endtask

	task automatic loadTrace();
		int fd;
		int n;
		int wordIdx;
		string line;
		logic [7:0] kind;
		logic [31:0] a;
		logic [31:0] b;
		wordIdx = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			iMem[i] = {12'(i), 20'h0_0013}; // addi x0,x0,index
			dMem[i] = 32'hda7a_0000 ^ i;
		end
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		fd = $fopen("dv/riscv_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file dv/riscv_trace.txt");
			otherErrors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%c %h %h", kind, a, b);
			case (kind)
				"I": begin
					if (wordIdx < MEM_WORDS) begin
						iMem[wordIdx] = a;
					end
					if (a == `HALT_INST) begin
						haltPc = 32'(wordIdx) << 2; // where the core should spin
					end
					wordIdx++;
				end
				"W": regQ.push_back({a, b});
				"S": storeQ.push_back({a, b});
				"N": expCount = a;
				default: begin
					$display("Trace line not understood: %s", line);
					otherErrors++;
				end
			endcase
		end
		$fclose(fd);
	endtask

	task automatic checkRegWrite();
		expT rec;
		if (regQ.size() == 0) begin
			$display("Register x%0d was written at %0t but no write was expected", rfWa, $time);
			otherErrors++;
		end else begin
			rec = regQ.pop_front();
			compareValues("register write address", 32'(rfWa), rec.addr);
			compareValues($sformatf("value written to x%0d", rfWa), rfWd, rec.data);
		end
	endtask

	task automatic checkStore();
		expT rec;
		if (storeQ.size() == 0) begin
			$display("Store to %h at %0t but no store was expected", dMemAddr, $time);
			otherErrors++;
		end else begin
			rec = storeQ.pop_front();
			compareValues("store address", 32'(dMemAddr), rec.addr);
			compareValues("store data", dMemDout, rec.data);
		end
	endtask

	// Outputs are settled by the falling edge
	always @(negedge CLK) begin
		if (rfWe && rfWa != 0) begin
			checkRegWrite();
		end
		if (!dMemCsn && !dMemWen) begin
			checkStore();
		end
	end

	task automatic runProgramChecks();
		@(negedge CLK);
		compareValues("iMemCsn in reset", 32'(iMemCsn), 32'd1);
		compareValues("rfWe in reset", 32'(rfWe), 32'd0);
		compareValues("dMemCsn in reset", 32'(dMemCsn), 32'd1);
		compareValues("dMemWen in reset", 32'(dMemWen), 32'd1);
		compareValues("numInst in reset", numInst, 32'd0);
		wait (RSTn == 1'b0);
		@(negedge CLK);
		compareValues("first fetch address", 32'(iMemAddr), `RESET_PC);
		compareValues("iMemCsn after reset", 32'(iMemCsn), 32'd0);
		compareValues("numInst after reset", numInst, 32'd0);

		while (!halt) begin
			@(negedge CLK);
		end
		compareValues("PC at halt", 32'(iMemAddr), haltPc);
		compareValues("numInst at halt", numInst, expCount);
		compareValues("rfWe while halted", 32'(rfWe), 32'd0);
		compareValues("dMemWen while halted", 32'(dMemWen), 32'd1);

		repeat (4) @(negedge CLK); // stray writes show up in the monitor
		compareValues("halt held", 32'(halt), 32'd1);
		compareValues("PC held on halt", 32'(iMemAddr), haltPc);
		compareValues("numInst after halt", numInst, expCount);
		if (regQ.size() != 0) begin
			$display("%0d expected register writes never happened", regQ.size());
			otherErrors++;
		end
		if (storeQ.size() != 0) begin
			$display("%0d expected stores never happened", storeQ.size());
			otherErrors++;
		end
	endtask

	task automatic finishRun();
		$display("Checks: %0d, mismatches: %0d, other failures: %0d",
			checkCount, errCount, otherErrors);
		if (errCount == 0 && otherErrors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	initial begin
		loadTrace();
		cycleLimit = 2 * int'(expCount) + 20;
		if (otherErrors == 0) begin
			runProgramChecks();
		end
		finishRun();
	end

	always @(posedge CLK) begin
		cycles <= cycles + 1;
	end

	initial begin
		@(posedge CLK);
		while (cycles < cycleLimit) begin
			@(posedge CLK);
		end
		$display("Timeout after %0d cycles, the core never reached its halt", cycles);
		otherErrors++;
		finishRun();
	end

endmodule

// ==== dv/riscv_trace.txt ====
# I word | W reg value | S byte-address data | N retired count
# All fields hex; I records fill the instruction memory from address 0
I 00500113 # 00 addi x2,x0,5
I ffd00193 # 04 addi x3,x0,-3
I 00310233 # 08 add x4,x2,x3
I 403102b3 # 0c sub x5,x2,x3
I 12345337 # 10 lui x6,0x12345
I 00001397 # 14 auipc x7,0x1
I 0f034413 # 18 xori x8,x6,0xf0
I 00411493 # 1c slli x9,x2,4
I 4011d513 # 20 srai x10,x3,1
I 0021d5b3 # 24 srl x11,x3,x2
I 0021a633 # 28 slt x12,x3,x2
I 0021b6b3 # 2c sltu x13,x3,x2
I 04602023 # 30 sw x6,0x40(x0)
I 04002703 # 34 lw x14,0x40(x0)
I 00410463 # 38 beq x2,x4,+8 not taken
I 00411463 # 3c bne x2,x4,+8 taken
I 00100793 # 40 skipped
I 0021c463 # 44 blt x3,x2,+8 taken
I 00200793 # 48 skipped
I 0021f463 # 4c bgeu x3,x2,+8 taken
I 00300793 # 50 skipped
I 0021d463 # 54 bge x3,x2,+8 not taken
I 00c0086f # 58 jal x16,+12
I 00400793 # 5c skipped
I 00500793 # 60 skipped
I 07400893 # 64 addi x17,x0,0x74
I 00488967 # 68 jalr x18,4(x17)
I 00600793 # 6c skipped
I 00700793 # 70 skipped
I 00800793 # 74 skipped
I 008379b3 # 78 and x19,x6,x8
I 00c4ea33 # 7c or x20,x9,x12
I 00c11ab3 # 80 sll x21,x2,x12
I 05502223 # 84 sw x21,0x44(x0)
I 00700013 # 88 addi x0,x0,7
I 00c00093 # 8c addi x1,x0,12
I 00008067 # 90 jalr x0,0(x1) halt
W 02 00000005
W 03 fffffffd
W 04 00000002
W 05 00000008
W 06 12345000
W 07 00001014
W 08 123450f0
W 09 00000050
W 0a fffffffe
W 0b 07ffffff
W 0c 00000001
W 0d 00000000
S 040 12345000
W 0e 12345000
W 10 0000005c
W 11 00000074
W 12 0000006c
W 13 12345000
W 14 00000051
W 15 0000000a
S 044 0000000a
W 01 0000000c
N 1c

// ==== riscvCore.f ====
+incdir+common
common/rvIsaPkg.sv
common/rvCtrlPkg.sv
logic/riscvDecoder.sv
logic/immGen.sv
logic/alu.sv
logic/nextPc.sv
logic/riscvTop.sv
dv/tbClock.sv
dv/tbRiscvTop.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module tbRiscvTop -f riscvCore.f -o tbRiscvTop &&
./obj_dir/tbRiscvTop | tee /dev/stderr | grep -F -x '** PASS **' > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
